// File: design/fe_cfg_pkg.sv
`default_nettype none

// sizing and start-up constants of the instruction fetch front end
package fe_cfg_pkg;

	// bus address and data widths, fetches are always word sized
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// one instruction parcel, the smallest unit the decoder consumes
	localparam int HW_W = 16;

	// two entries is the least that keeps fetch at full rate while decode stalls
	localparam int QUEUE_DEPTH = 2;

	// number of fetches allowed in flight on the bus at once
	localparam int MAX_PENDING = 2;

	// first fetch address after reset
	localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0100;

endpackage

`default_nettype wire

// File: design/fe_types_pkg.sv
`default_nettype none

// types that travel between the fetch front end blocks
package fe_types_pkg;

	// byte address on the fetch bus
	typedef logic [fe_cfg_pkg::ADDR_W-1:0] fetch_addr_t;
	// one bus data word, two parcels
	typedef logic [fe_cfg_pkg::DATA_W-1:0] fetch_word_t;
	typedef logic [fe_cfg_pkg::HW_W-1:0]   halfword_t;

	// bit 0 flags the lower halfword of a word
	typedef logic [1:0] hw_mask_t;
	// halfword count, 0 to 3
	typedef logic [1:0] hw_count_t;
	// fetches outstanding on the bus
	typedef logic [1:0] pend_count_t;

	typedef enum logic [1:0] {
		RESET_WAIT,
		ISSUE,
		ADDR_HOLD
	} seq_state_e;

endpackage

`default_nettype wire

// File: design/fe_resp_if.sv
`default_nettype none

// a fetch response after the flush filter
// word and err come straight from the bus data phase
interface fe_resp_if;
	import fe_types_pkg::*;

	fetch_word_t word;
	logic        err;
	// which halfwords of the word belong to the instruction stream
	hw_mask_t    hw_mask;
	// low while the response belongs to a fetch that a jump discarded
	logic        vld;

	// the tracker filters and produces the response
	modport src (
		output word, err, hw_mask, vld
	);

	// the queue and the aligner both watch the same response
	modport snk (
		input word, err, hw_mask, vld
	);

endinterface

`default_nettype wire

// File: design/fe_head_if.sv
`default_nettype none

// oldest prefetch queue entry, offered to the aligner
interface fe_head_if;
	import fe_types_pkg::*;

	fetch_word_t word;
	logic        err;
	hw_mask_t    hw_mask;
	logic        vld;
	// aligner consumes one word this cycle, from the head or else from the bypass
	logic        take;

	modport queue (
		output word, err, hw_mask, vld,
		input  take
	);

	modport aligner (
		input  word, err, hw_mask, vld,
		output take
	);

endinterface

`default_nettype wire

// File: design/fetch_sequencer.sv
`default_nettype none

module fetch_sequencer (
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	input  wire fe_types_pkg::fetch_addr_t jump_target,
	input  wire logic                      jump_vld,
	output logic                           jump_rdy,
	input  wire logic                      issue_ok,
	output fe_types_pkg::fetch_addr_t      mem_addr,
	output logic                           mem_addr_vld,
	input  wire logic                      mem_addr_rdy,
	output logic                           jump_now
);
	import fe_cfg_pkg::*;
	import fe_types_pkg::*;

	seq_state_e  state;
	seq_state_e  state_nxt;
	// runs ahead of the decoder in whole words
	fetch_addr_t fetch_addr;
	fetch_addr_t jump_base;
	logic        accepted;

	// the bus only sees word aligned addresses
	assign jump_base = {jump_target[ADDR_W-1:2], 2'b00};

	// a held address phase must not change, so jumps wait for it
	assign jump_rdy = state != ADDR_HOLD;
	assign jump_now = jump_vld && jump_rdy;
	assign accepted = mem_addr_vld && mem_addr_rdy;

	// --------------------------------------------------
	// address phase
	always_comb begin
		mem_addr     = fetch_addr;
		mem_addr_vld = 1'b0;
		state_nxt    = state;
		case (state)
			RESET_WAIT: begin
				// one quiet cycle after reset before the first request
				state_nxt = ISSUE;
			end
			ISSUE: begin
				// a jump goes straight out, otherwise sequential fetch
				mem_addr_vld = issue_ok;
				if (jump_vld) begin
					mem_addr = jump_base;
				end
				if (issue_ok && !mem_addr_rdy) begin
					state_nxt = ADDR_HOLD;
				end
			end
			ADDR_HOLD: begin
				// fetch_addr already holds the stalled address, jump or not
				mem_addr_vld = 1'b1;
				if (mem_addr_rdy) begin
					state_nxt = ISSUE;
				end
			end
			default: begin
				state_nxt = RESET_WAIT;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= RESET_WAIT;
			fetch_addr <= RESET_PC;
		end else begin
			state <= state_nxt;
			// step past the jump target if it was accepted in the same cycle
			if (jump_now) begin
				fetch_addr <= jump_base + (accepted ? fetch_addr_t'(4) : fetch_addr_t'(0));
			end else if (accepted) begin
				fetch_addr <= fetch_addr + fetch_addr_t'(4);
			end
		end
	end

endmodule

`default_nettype wire

// File: design/fetch_tracker.sv
`default_nettype none

module fetch_tracker (
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	input  wire logic                      mem_addr_vld,
	input  wire logic                      mem_addr_rdy,
	input  wire logic                      jump_now,
	input  wire logic                      jump_odd,
	input  wire fe_types_pkg::fetch_word_t mem_data,
	input  wire logic                      mem_data_err,
	input  wire logic                      mem_data_vld,
	input  wire fe_types_pkg::hw_count_t   queue_level,
	output logic                           issue_ok,
	fe_resp_if.src                         resp
);
	import fe_cfg_pkg::*;
	import fe_types_pkg::*;

	pend_count_t pending;
	// responses still to be thrown away after the last jump
	pend_count_t flush_cnt;
	// mask for the request in the address phase and for the next kept response
	hw_mask_t    aph_mask;
	hw_mask_t    dph_mask;
	logic        accepted;
	logic        flushing;
	logic        bus_ok;
	logic        queue_ok;

	assign accepted = mem_addr_vld && mem_addr_rdy;
	assign flushing = flush_cnt != '0;

	// --------------------------------------------------
	// issue credit
	// registered counts only, so there is no path from bus handshakes to the request
	assign bus_ok   = pending < pend_count_t'(MAX_PENDING);
	assign queue_ok = queue_level < hw_count_t'(QUEUE_DEPTH) &&
		!(queue_level == hw_count_t'(QUEUE_DEPTH - 1) && pending != '0);
	// a jump empties the queue, so only the bus limit applies to it
	assign issue_ok = bus_ok && (queue_ok || jump_now);

	assign resp.word    = mem_data;
	assign resp.err     = mem_data_err;
	assign resp.hw_mask = dph_mask;
	assign resp.vld     = mem_data_vld && !flushing;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending   <= '0;
			flush_cnt <= '0;
		end else begin
			pending <= pending + pend_count_t'(accepted) - pend_count_t'(mem_data_vld);
			// everything older than the jump is discarded, including data landing now
			if (jump_now) begin
				flush_cnt <= pending - pend_count_t'(mem_data_vld);
			end else if (flushing && mem_data_vld) begin
				flush_cnt <= flush_cnt - 1'b1;
			end
		end
	end

	// only the first fetch after a jump to an odd halfword drops its lower half
	// every older fetch is flushed by then, so one data phase mask is enough
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			aph_mask <= 2'b11;
			dph_mask <= 2'b11;
		end else if (jump_now) begin
			if (accepted) begin
				aph_mask <= 2'b11;
				dph_mask <= {1'b1, !jump_odd};
			end else begin
				aph_mask <= {1'b1, !jump_odd};
				dph_mask <= 2'b11;
			end
		end else begin
			if (accepted) begin
				aph_mask <= 2'b11;
			end
			if (accepted && !aph_mask[0]) begin
				dph_mask <= aph_mask;
			end else if (resp.vld) begin
				dph_mask <= 2'b11;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/prefetch_queue.sv
`default_nettype none

module prefetch_queue (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                jump_now,
	fe_resp_if.snk                   resp,
	fe_head_if.queue                 head,
	output fe_types_pkg::hw_count_t  level
);
	import fe_cfg_pkg::*;
	import fe_types_pkg::*;

	fetch_word_t            word_q [QUEUE_DEPTH];
	logic                   err_q  [QUEUE_DEPTH];
	hw_mask_t               mask_q [QUEUE_DEPTH];
	// valid entries always sit at the bottom, entry 0 is the oldest
	logic [QUEUE_DEPTH-1:0] vld_q;

	// the entry above each slot, empty above the top one
	fetch_word_t up_word [QUEUE_DEPTH];
	logic        up_err  [QUEUE_DEPTH];
	hw_mask_t    up_mask [QUEUE_DEPTH];
	logic        up_vld  [QUEUE_DEPTH];

	logic      push;
	logic      pop;
	// fill level once the pop has shifted everything down
	hw_count_t sh_level;

	for (genvar i = 0; i < QUEUE_DEPTH; i++) begin : g_up
		if (i < QUEUE_DEPTH - 1) begin : g_mid
			assign up_word[i] = word_q[i+1];
			assign up_err[i]  = err_q[i+1];
			assign up_mask[i] = mask_q[i+1];
			assign up_vld[i]  = vld_q[i+1];
		end else begin : g_top
			assign up_word[i] = '0;
			assign up_err[i]  = 1'b0;
			assign up_mask[i] = '0;
			assign up_vld[i]  = 1'b0;
		end
	end

	assign head.word    = word_q[0];
	assign head.err     = err_q[0];
	assign head.hw_mask = mask_q[0];
	assign head.vld     = vld_q[0];

	// an empty queue lets a taken response bypass it
	assign pop  = head.take && vld_q[0];
	assign push = resp.vld && !(head.take && !vld_q[0]);

	always_comb begin
		level = '0;
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			level = level + hw_count_t'(vld_q[i]);
		end
	end

	assign sh_level = level - hw_count_t'(pop);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_q <= '0;
		end else begin
			for (int i = 0; i < QUEUE_DEPTH; i++) begin
				vld_q[i] <= !jump_now && ((pop ? up_vld[i] : vld_q[i]) ||
					(push && hw_count_t'(i) == sh_level));
			end
		end
	end

	// payload shifts down on a pop, the new word lands in the first free slot
	always_ff @(posedge clk) begin
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			if (pop && up_vld[i]) begin
				word_q[i] <= up_word[i];
				err_q[i]  <= up_err[i];
				mask_q[i] <= up_mask[i];
			end else if (push && hw_count_t'(i) == sh_level) begin
				word_q[i] <= resp.word;
				err_q[i]  <= resp.err;
				mask_q[i] <= resp.hw_mask;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/instr_aligner.sv
`default_nettype none

module instr_aligner (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire logic                     jump_now,
	input  wire fe_types_pkg::hw_count_t  cir_use,
	fe_resp_if.snk                        resp,
	fe_head_if.aligner                    head,
	output fe_types_pkg::fetch_word_t     cir,
	output fe_types_pkg::hw_count_t       cir_vld,
	output fe_types_pkg::hw_mask_t        cir_err
);
	import fe_cfg_pkg::*;
	import fe_types_pkg::*;

	// spill halfword above cir, the yard is {hwbuf, cir}
	halfword_t         hwbuf;
	logic [2:0]        err_q;
	// valid halfwords in the yard, 0 to 3
	hw_count_t         level;
	hw_count_t         level_used;
	hw_count_t         level_nxt;
	hw_count_t         fill;
	fetch_word_t       fetch_word;
	hw_mask_t          fetch_mask;
	logic              fetch_err;
	logic              fetch_vld;
	logic              room;
	logic [2*HW_W-1:0] fetch_aligned;
	logic [3*HW_W-1:0] yard_shifted;
	logic [3*HW_W-1:0] yard_nxt;
	logic [2:0]        err_shifted;
	logic [2:0]        err_nxt;

	// --------------------------------------------------
	// fetch source, queue head first and the live response when it is empty
	assign fetch_word = head.vld ? head.word : resp.word;
	assign fetch_mask = head.vld ? head.hw_mask : resp.hw_mask;
	assign fetch_err  = head.vld ? head.err : resp.err;
	assign fetch_vld  = head.vld || resp.vld;

	// move the upper halfword down when the lower one is not part of the stream
	assign fetch_aligned = {
		fetch_word[HW_W +: HW_W],
		fetch_mask[0] ? fetch_word[0 +: HW_W] : fetch_word[HW_W +: HW_W]
	};
	assign fill = fetch_mask[0] ? hw_count_t'(2) : hw_count_t'(1);

	// whatever the decoder leaves behind stays, fresh data only goes on top
	assign level_used = level - cir_use;
	assign room       = level_used <= (fetch_mask[0] ? hw_count_t'(1) : hw_count_t'(2));
	assign head.take  = room && fetch_vld;

	// --------------------------------------------------
	// yard update
	always_comb begin
		// halfwords above the new level are don't care, so they just repeat hwbuf
		case (cir_use)
			2'd1:    yard_shifted = {hwbuf, hwbuf, cir[HW_W +: HW_W]};
			2'd2:    yard_shifted = {hwbuf, hwbuf, hwbuf};
			default: yard_shifted = {hwbuf, cir};
		endcase
		err_shifted = err_q >> cir_use;

		yard_nxt = yard_shifted;
		err_nxt  = err_shifted;
		if (head.take) begin
			case (level_used)
				2'd0: begin
					yard_nxt[0 +: 2*HW_W] = fetch_aligned;
					err_nxt[1:0]          = {2{fetch_err}};
				end
				2'd1: begin
					yard_nxt[HW_W +: 2*HW_W] = fetch_aligned;
					err_nxt[2:1]             = {2{fetch_err}};
				end
				default: begin
					// only half a word fits, which room allows for partial words alone
					yard_nxt[2*HW_W +: HW_W] = fetch_aligned[0 +: HW_W];
					err_nxt[2]               = fetch_err;
				end
			endcase
		end
	end

	assign level_nxt = jump_now ? '0 : level_used + (head.take ? fill : hw_count_t'(0));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level   <= '0;
			cir_vld <= '0;
		end else begin
			level <= level_nxt;
			// the decoder sees at most the two halfwords of cir
			cir_vld <= level_nxt[1] ? hw_count_t'(2) : level_nxt;
		end
	end

	always_ff @(posedge clk) begin
		{hwbuf, cir} <= yard_nxt;
		err_q        <= err_nxt;
	end

	// error flags of halfwords beyond the fill level are stale
	assign cir_err = err_q[1:0] & {cir_vld[1], cir_vld != '0};

endmodule

`default_nettype wire

// File: design/fetch_frontend.sv
`default_nettype none

module fetch_frontend (
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	// fetch bus, valid/ready address phase and an unstalled data phase
	output fe_types_pkg::fetch_addr_t      mem_addr,
	output logic                           mem_addr_vld,
	input  wire logic                      mem_addr_rdy,
	input  wire fe_types_pkg::fetch_word_t mem_data,
	input  wire logic                      mem_data_err,
	input  wire logic                      mem_data_vld,
	// jump request from later pipeline stages
	input  wire fe_types_pkg::fetch_addr_t jump_target,
	input  wire logic                      jump_vld,
	output logic                           jump_rdy,
	// current instruction register towards decode
	output fe_types_pkg::fetch_word_t      cir,
	output fe_types_pkg::hw_count_t        cir_vld,
	input  wire fe_types_pkg::hw_count_t   cir_use,
	output fe_types_pkg::hw_mask_t         cir_err
);
	import fe_types_pkg::*;

	logic      jump_now;
	logic      issue_ok;
	hw_count_t queue_level;

	fe_resp_if u_resp ();
	fe_head_if u_head ();

	// --------------------------------------------------
	// request side
	fetch_sequencer u_seq (
		.clk          (clk),
		.rst_n        (rst_n),
		.jump_target  (jump_target),
		.jump_vld     (jump_vld),
		.jump_rdy     (jump_rdy),
		.issue_ok     (issue_ok),
		.mem_addr     (mem_addr),
		.mem_addr_vld (mem_addr_vld),
		.mem_addr_rdy (mem_addr_rdy),
		.jump_now     (jump_now)
	);

	// bit 1 of the target says the jump lands on an upper halfword
	fetch_tracker u_trk (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_addr_vld (mem_addr_vld),
		.mem_addr_rdy (mem_addr_rdy),
		.jump_now     (jump_now),
		.jump_odd     (jump_target[1]),
		.mem_data     (mem_data),
		.mem_data_err (mem_data_err),
		.mem_data_vld (mem_data_vld),
		.queue_level  (queue_level),
		.issue_ok     (issue_ok),
		.resp         (u_resp.src)
	);

	// --------------------------------------------------
	// response side
	prefetch_queue u_q (
		.clk      (clk),
		.rst_n    (rst_n),
		.jump_now (jump_now),
		.resp     (u_resp.snk),
		.head     (u_head.queue),
		.level    (queue_level)
	);

	instr_aligner u_aln (
		.clk      (clk),
		.rst_n    (rst_n),
		.jump_now (jump_now),
		.cir_use  (cir_use),
		.resp     (u_resp.snk),
		.head     (u_head.aligner),
		.cir      (cir),
		.cir_vld  (cir_vld),
		.cir_err  (cir_err)
	);

endmodule

`default_nettype wire

// File: test/fetch_frontend_checker.sv
`default_nettype none

// bus protocol and cir rules, watched from the top level ports
module fetch_frontend_checker (
	input wire logic                      clk,
	input wire logic                      rst_n,
	input wire fe_types_pkg::fetch_addr_t mem_addr,
	input wire logic                      mem_addr_vld,
	input wire logic                      mem_addr_rdy,
	input wire logic                      mem_data_vld,
	input wire logic                      jump_vld,
	input wire logic                      jump_rdy,
	input wire fe_types_pkg::hw_count_t   cir_vld
);
	timeunit 1ns;
	timeprecision 1ps;

	import fe_cfg_pkg::*;

	// failed assertions, read back by the testbench
	int unsigned fail_cnt = 0;
	// fetches accepted on the bus and not yet answered
	int unsigned bus_pending;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bus_pending <= 0;
		end else begin
			bus_pending <= bus_pending + (mem_addr_vld && mem_addr_rdy) - mem_data_vld;
		end
	end

	// --------------------------------------------------
	// bus side
	a_addr_held: assert property (@(posedge clk) disable iff (!rst_n)
		mem_addr_vld && !mem_addr_rdy |=> mem_addr_vld && $stable(mem_addr))
	else begin
		$error("address phase changed or dropped before mem_addr_rdy");
		fail_cnt++;
	end

	a_pending_max: assert property (@(posedge clk) disable iff (!rst_n)
		bus_pending <= MAX_PENDING)
	else begin
		$error("more fetches outstanding on the bus than allowed");
		fail_cnt++;
	end

	// a wrapped count also lands here
	a_no_orphan_data: assert property (@(posedge clk) disable iff (!rst_n)
		mem_data_vld |-> bus_pending != 0 && bus_pending <= MAX_PENDING)
	else begin
		$error("fetch data arrived with no fetch outstanding");
		fail_cnt++;
	end

	// jumps are only refused while an address phase is stuck
	a_jump_rdy: assert property (@(posedge clk) disable iff (!rst_n)
		!jump_rdy |-> mem_addr_vld)
	else begin
		$error("jump_rdy low without a held address phase");
		fail_cnt++;
	end

	// --------------------------------------------------
	// decode side
	a_jump_clears_cir: assert property (@(posedge clk) disable iff (!rst_n)
		jump_vld && jump_rdy |=> cir_vld == 0)
	else begin
		$error("cir still valid on the cycle after a jump");
		fail_cnt++;
	end

	a_cir_vld_max: assert property (@(posedge clk) disable iff (!rst_n)
		cir_vld <= 2)
	else begin
		$error("cir_vld reports more than two halfwords");
		fail_cnt++;
	end

endmodule

bind fetch_frontend fetch_frontend_checker u_chk (.*);

`default_nettype wire

// File: test/fetch_frontend_tb.sv
`default_nettype none

module fetch_frontend_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import fe_cfg_pkg::*;
	import fe_types_pkg::*;

	localparam int NUM_TESTS  = 4;
	localparam int CLK_PERIOD = 100;

	logic        clk;
	logic        rst_n;
	fetch_addr_t mem_addr;
	logic        mem_addr_vld;
	logic        mem_addr_rdy;
	fetch_word_t mem_data;
	logic        mem_data_err;
	logic        mem_data_vld;
	fetch_addr_t jump_target;
	logic        jump_vld;
	logic        jump_rdy;
	fetch_word_t cir;
	hw_count_t   cir_vld;
	hw_count_t   cir_use;
	hw_mask_t    cir_err;
	// halfwords the decoder would like to take this cycle
	hw_count_t   use_req;

	integer      seed = 74;
	int          cycle;
	int          tb_fails;
	int          consumed;
	int          jumps_taken;
	int          passed;
	int          failed;
	// stimulus controls, written by the sequence on the falling edge
	logic        run;
	logic        stall;
	logic        rand_jumps;
	logic        forced_jump;
	fetch_addr_t forced_target;
	// next halfword the decoder should see, and next word the bus should see
	fetch_addr_t exp_hw_addr;
	fetch_addr_t exp_fetch;
	// accepted fetches waiting for their data phase
	fetch_addr_t pend_addr[$];
	int          pend_due[$];
	int          last_due;

	fetch_frontend u_fetch_frontend (.*);

	// the decoder never takes more than cir holds
	assign cir_use = (use_req > cir_vld) ? cir_vld : use_req;

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// each memory halfword holds bits 16:1 of its own byte address
	function automatic halfword_t hw_at(fetch_addr_t a);
		return a[16:1];
	endfunction

	// an error region every 256 bytes
	function automatic logic err_at(fetch_addr_t a);
		return &a[7:4];
	endfunction

	function automatic int error_total();
		return tb_fails + int'(u_fetch_frontend.u_chk.fail_cnt);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
			tb_fails++;
		end
	endtask

	// --------------------------------------------------
	// bus memory, decoder and expected stream
	always @(posedge clk) begin : bus_and_decode
		logic        jumped;
		logic [31:0] rnd;
		int          due;
		fetch_addr_t word_addr;
		fetch_addr_t jump_base;
		hw_mask_t    err_exp;
		if (run) begin
			cycle++;
			jumped    = jump_vld && jump_rdy;
			jump_base = {jump_target[ADDR_W-1:2], 2'b00};

			// address phase of the cycle that just closed
			if (mem_addr_vld && mem_addr_rdy) begin
				if (jumped) begin
					check_value("mem_addr", mem_addr, jump_base);
					exp_fetch = jump_base + 32'd4;
				end else begin
					check_value("mem_addr", mem_addr, exp_fetch);
					exp_fetch = exp_fetch + 32'd4;
				end
				// latency of 1 to 3 cycles, kept in order
				due = cycle + 1 + int'($unsigned($random(seed)) % 3);
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due = due;
				pend_addr.push_back(mem_addr);
				pend_due.push_back(due);
			end else if (jumped) begin
				exp_fetch = jump_base;
			end

			// cir against the expected halfword stream
			// halfwords that are not valid must not flag an error
			err_exp = 2'b00;
			if (cir_vld != 0) begin
				check_value("cir[15:0]", cir[15:0], hw_at(exp_hw_addr));
				err_exp[0] = err_at(exp_hw_addr);
			end
			if (cir_vld == 2) begin
				check_value("cir[31:16]", cir[31:16], hw_at(exp_hw_addr + 32'd2));
				err_exp[1] = err_at(exp_hw_addr + 32'd2);
			end
			check_value("cir_err", cir_err, err_exp);
			if (jumped) begin
				exp_hw_addr = jump_target;
				jumps_taken++;
			end else begin
				exp_hw_addr = exp_hw_addr + fetch_addr_t'(2 * cir_use);
				consumed    = consumed + int'(cir_use);
			end

			// data phase of the coming cycle
			if (pend_due.size() != 0 && pend_due[0] <= cycle + 1) begin
				word_addr = pend_addr.pop_front();
				due       = pend_due.pop_front();
				mem_data_vld <= 1'b1;
				mem_data     <= {hw_at(word_addr + 32'd2), hw_at(word_addr)};
				mem_data_err <= err_at(word_addr);
			end else begin
				mem_data_vld <= 1'b0;
				mem_data     <= '0;
				mem_data_err <= 1'b0;
			end

			mem_addr_rdy <= ($unsigned($random(seed)) % 4) != 0;
			use_req      <= stall ? hw_count_t'(0) : hw_count_t'($unsigned($random(seed)) % 3);

			// a jump request stays up until it is taken
			if (jumped) begin
				jump_vld <= 1'b0;
			end
			if (!jump_vld || jumped) begin
				rnd = $random(seed);
				if (forced_jump) begin
					jump_vld    <= 1'b1;
					jump_target <= forced_target;
					forced_jump = 1'b0;
				end else if (rand_jumps && rnd[31:27] == 5'd0) begin
					jump_vld    <= 1'b1;
					jump_target <= {16'h0000, rnd[15:1], 1'b0};
				end
			end
		end
	end

	task automatic wait_consumed(input int n);
		int target;
		target = consumed + n;
		while (consumed < target) begin
			@(negedge clk);
		end
	endtask

	task automatic jump_to(input fetch_addr_t target);
		int start;
		start         = jumps_taken;
		forced_target = target;
		forced_jump   = 1'b1;
		while (jumps_taken == start) begin
			@(negedge clk);
		end
	endtask

	task automatic report_test(input int num, input string name, input int errs_before);
		int errs;
		errs = error_total() - errs_before;
		if (errs == 0) begin
			passed++;
			$display("test %0d %s passed", num, name);
		end else begin
			failed++;
			$display("test %0d %s failed with %0d errors", num, name, errs);
		end
	endtask

	// --------------------------------------------------
	// test sequence
	initial begin : sequence_tests
		int errs_before;
		int start;
		rst_n         = 1'b0;
		mem_addr_rdy  = 1'b0;
		mem_data      = '0;
		mem_data_err  = 1'b0;
		mem_data_vld  = 1'b0;
		jump_target   = '0;
		jump_vld      = 1'b0;
		use_req       = '0;
		run           = 1'b0;
		stall         = 1'b0;
		rand_jumps    = 1'b0;
		forced_jump   = 1'b0;
		forced_target = '0;
		exp_hw_addr   = RESET_PC;
		exp_fetch     = RESET_PC;
		last_due      = 0;

		repeat (4) @(posedge clk);
		check_value("mem_addr_vld", mem_addr_vld, 1'b0);
		check_value("cir_vld", cir_vld, 2'd0);
		check_value("cir_err", cir_err, 2'b00);
		check_value("jump_rdy", jump_rdy, 1'b1);
		rst_n <= 1'b1;
		run   <= 1'b1;
		@(negedge clk);

		// straight line code from the reset address, through an error region
		errs_before = error_total();
		wait_consumed(320);
		report_test(1, "sequential fetch", errs_before);

		// stalled decode fills cir and the queue, then drains without loss
		errs_before = error_total();
		stall = 1'b1;
		while (cir_vld != 2) begin
			@(negedge clk);
		end
		repeat (12) @(negedge clk);
		check_value("cir_vld", cir_vld, 2'd2);
		stall = 1'b0;
		wait_consumed(100);
		report_test(2, "decoder stall", errs_before);

		errs_before = error_total();
		start       = jumps_taken;
		rand_jumps  = 1'b1;
		while (jumps_taken < start + 40) begin
			@(negedge clk);
		end
		rand_jumps = 1'b0;
		wait_consumed(40);
		report_test(3, "random jumps", errs_before);

		// odd target inside an error word, then an even one just before it
		errs_before = error_total();
		jump_to(32'h0000_21f2);
		wait_consumed(30);
		jump_to(32'h0000_31ec);
		wait_consumed(30);
		report_test(4, "directed jumps", errs_before);

		$display("tests: %0d passed, %0d failed, %0d check errors",
			passed, failed, error_total());
		if (failed == 0 && error_total() == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// ends a run that stops making progress
	initial begin : watchdog
		repeat (NUM_TESTS * 2000) @(posedge clk);
		$display("watchdog expired after %0d cycles, the tests did not finish",
			NUM_TESTS * 2000);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
design/fe_cfg_pkg.sv
design/fe_types_pkg.sv
design/fe_resp_if.sv
design/fe_head_if.sv
design/fetch_sequencer.sv
design/fetch_tracker.sv
design/prefetch_queue.sv
design/instr_aligner.sv
design/fetch_frontend.sv
test/fetch_frontend_checker.sv
test/fetch_frontend_tb.sv
